/* cpu_core.f */
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/register_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/cpu_core.sv
testbench/cpu_core_tb.sv

/* Makefile */
# Verilator build and run of the cpu_core testbench

VERILATOR ?= verilator
TOP       ?= cpu_core_tb
FILELIST  ?= cpu_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^Simulation PASSED$$" $(LOG) || (echo "run failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/cpu_core_tb.sv */
`timescale 1ns/100ps

module cpu_core_tb
    import isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int          RANDOM_COUNT   = 400;
    localparam int          DIRECTED_BOUND = 100;   // directed part stays below this
    localparam int          CYCLE_LIMIT    = 40 * (DIRECTED_BOUND + RANDOM_COUNT) + 200;
    localparam logic [31:0] SEED           = 32'd68878;
    localparam opcode_e     ALU_OPS [9]    = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ROTR,
                                               OP_ROTL, OP_SHR, OP_SHRA, OP_SHL};
    localparam opcode_e     ALL_OPS [19]   = '{OP_LD, OP_ST, OP_ADD, OP_SUB, OP_AND, OP_OR,
                                               OP_ROTR, OP_ROTL, OP_SHR, OP_SHRA, OP_SHL,
                                               OP_ADDI, OP_ANDI, OP_ORI, OP_MUL, OP_NEG,
                                               OP_NOT, OP_MFLO, OP_MFHI};

    logic        clock;
    logic        rst;
    logic        instr_valid;
    instr_word_u instr;
    logic        instr_ready;
    logic        retire_valid;
    retire_s     retire;
    logic        retire_ready;

    logic [31:0] m_regs [REG_COUNT];    // reference machine state
    logic [31:0] m_mem [DATA_DEPTH];
    logic [31:0] m_hi;
    logic [31:0] m_lo;

    retire_s     expected_q [$];
    retire_s     exp_rec;
    logic [31:0] stim_state;
    logic [31:0] ready_state;
    logic        random_ready;
    int          sent_count;
    int          retired_count = 0;
    int          check_count   = 0;
    int          error_count   = 0;
    int          cycle_count   = 0;

    cpu_core dut (
        .clock        (clock),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_ready  (instr_ready),
        .retire_valid (retire_valid),
        .retire       (retire),
        .retire_ready (retire_ready)
    );

    initial
    begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;   // taps 32, 22, 2, 1
        return s >> 1;
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v     = {v[30:0], state[0]};
            state = lfsr_next(state);
        end
        return v;
    endfunction

    function automatic instr_word_u r_instr(input opcode_e op, input int ra, input int rb,
                                            input int rc);
        instr_word_u w;
        w               = '0;
        w.r_form.opcode = op;
        w.r_form.ra     = REG_W'(ra);
        w.r_form.rb     = REG_W'(rb);
        w.r_form.rc     = REG_W'(rc);
        return w;
    endfunction

    function automatic instr_word_u i_instr(input opcode_e op, input int ra, input int rb,
                                            input int imm);
        instr_word_u w;
        w               = '0;
        w.i_form.opcode = op;
        w.i_form.ra     = REG_W'(ra);
        w.i_form.rb     = REG_W'(rb);
        w.i_form.imm    = 19'(imm);
        return w;
    endfunction

    // instruction-set model, returns the record the core should retire
    function automatic retire_s model_step(input instr_word_u w);
        retire_s            r;
        opcode_e            op;
        logic [31:0]        a_val;
        logic [31:0]        b_val;
        logic [31:0]        imm;
        logic [31:0]        res;
        logic [4:0]         sh;
        logic signed [63:0] prod;
        logic [DATA_AW-1:0] widx;
        op          = w.r_form.opcode;
        a_val       = m_regs[w.r_form.rb];
        b_val       = m_regs[w.r_form.rc];
        imm         = {{13{w.i_form.imm[18]}}, w.i_form.imm};
        sh          = b_val[4:0];
        widx        = DATA_AW'(a_val + imm);   // ld/st address wraps on the RAM size
        r.dest      = w.r_form.ra;
        r.reg_write = 1'b1;
        case (op)
            OP_ADD:  res = a_val + b_val;
            OP_SUB:  res = a_val - b_val;
            OP_AND:  res = a_val & b_val;
            OP_OR:   res = a_val | b_val;
            OP_ROTR: res = (a_val >> sh) | (a_val << (6'd32 - {1'b0, sh}));
            OP_ROTL: res = (a_val << sh) | (a_val >> (6'd32 - {1'b0, sh}));
            OP_SHR:  res = a_val >> sh;
            OP_SHRA: res = $signed(a_val) >>> sh;
            OP_SHL:  res = a_val << sh;
            OP_ADDI: res = a_val + imm;
            OP_ANDI: res = a_val & imm;
            OP_ORI:  res = a_val | imm;
            OP_NEG:  res = 32'd0 - a_val;
            OP_NOT:  res = ~a_val;
            OP_MFHI: res = m_hi;
            OP_MFLO: res = m_lo;
            OP_LD:   res = m_mem[widx];
            OP_MUL:
            begin
                prod = $signed({{32{a_val[31]}}, a_val}) * $signed({{32{b_val[31]}}, b_val});
                m_hi = prod[63:32];
                m_lo = prod[31:0];
                res  = m_lo;
            end
            OP_ST:
            begin
                res         = m_regs[w.r_form.ra];   // store data comes from ra
                m_mem[widx] = res;
                r.reg_write = 1'b0;
            end
            default: res = '0;
        endcase
        r.value = res;
        if (r.reg_write && (w.r_form.ra != '0))
            m_regs[w.r_form.ra] = res;
        return r;
    endfunction

    // called at 1 ns after a rising edge, returns at the same point after the transfer
    task automatic send_instr(input instr_word_u w);
        instr_valid = 1'b1;
        instr       = w;
        @(negedge clock);
        while (!instr_ready)
            @(negedge clock);
        @(posedge clock);
        #1;
        instr_valid = 1'b0;
    endtask

    task automatic issue(input instr_word_u w);
        expected_q.push_back(model_step(w));
        sent_count++;
        send_instr(w);
    endtask

    task automatic alu_op_sweep();
        issue(i_instr(OP_ADDI, 1, 0, 74565));
        issue(i_instr(OP_ADDI, 2, 0, -5));       // negative operand
        issue(i_instr(OP_ADDI, 4, 0, 31));
        issue(i_instr(OP_ADDI, 5, 0, 0));
        issue(i_instr(OP_ADDI, 6, 0, 12));
        issue(r_instr(OP_SHL, 3, 1, 6));
        issue(r_instr(OP_OR, 3, 3, 1));
        for (int i = 0; i < 9; i++)
        begin
            issue(r_instr(ALU_OPS[i], 7, 3, 6));
            issue(r_instr(ALU_OPS[i], 8, 2, 4));  // by 31
            issue(r_instr(ALU_OPS[i], 9, 3, 5));  // by 0
            issue(r_instr(ALU_OPS[i], 10, 2, 6));
        end
        issue(i_instr(OP_ADDI, 11, 2, -100));
        issue(i_instr(OP_ANDI, 12, 3, -256));
        issue(i_instr(OP_ANDI, 13, 3, 262143));
        issue(i_instr(OP_ORI, 14, 2, 1000));
        issue(r_instr(OP_NEG, 7, 3, 0));
        issue(r_instr(OP_NEG, 9, 2, 0));
        issue(r_instr(OP_NOT, 8, 2, 0));
    endtask

    task automatic mul_hilo_sequence();
        issue(r_instr(OP_MUL, 7, 3, 2));
        issue(r_instr(OP_MFHI, 8, 0, 0));
        issue(r_instr(OP_MFLO, 9, 0, 0));
        issue(r_instr(OP_MUL, 10, 3, 3));       // large positive product
        issue(r_instr(OP_MFHI, 11, 0, 0));
        issue(r_instr(OP_MFLO, 12, 0, 0));
    endtask

    task automatic load_store_pairs();
        issue(i_instr(OP_ST, 3, 0, 16));
        issue(i_instr(OP_LD, 7, 0, 16));
        issue(i_instr(OP_ST, 2, 6, 5));         // address 17 through a base register
        issue(i_instr(OP_LD, 8, 0, 17));
        issue(i_instr(OP_LD, 9, 0, 200));       // never written
        issue(i_instr(OP_LD, 10, 0, -1));       // wraps to the last word
    endtask

    task automatic dependency_chain();
        issue(i_instr(OP_ADDI, 1, 1, 1));
        issue(i_instr(OP_ADDI, 1, 1, 1));
        issue(i_instr(OP_ADDI, 1, 1, 1));
        issue(r_instr(OP_ADD, 2, 1, 1));
        issue(r_instr(OP_SUB, 3, 2, 1));
        issue(i_instr(OP_ORI, 0, 1, 77));       // r0 write has no effect
        issue(r_instr(OP_ADD, 4, 0, 1));
        issue(r_instr(OP_OR, 5, 0, 0));
        issue(i_instr(OP_LD, 6, 0, 16));
        issue(i_instr(OP_ADDI, 7, 6, 3));       // uses the loaded value
    endtask

    task automatic random_stream();
        opcode_e op;
        int      idx;
        int      ra;
        int      rb;
        int      rc;
        int      imm;
        for (int n = 0; n < RANDOM_COUNT; n++)
        begin
            idx = int'(take_bits(stim_state, 5) % 32'd19);
            op  = ALL_OPS[idx];
            ra  = int'(take_bits(stim_state, 3));   // low registers for frequent hazards
            rb  = int'(take_bits(stim_state, 3));
            if (op inside {OP_LD, OP_ST})
            begin
                imm = int'(take_bits(stim_state, 8));
                issue(i_instr(op, ra, rb, imm));
            end
            else if (op inside {OP_ADDI, OP_ANDI, OP_ORI})
            begin
                imm = int'(take_bits(stim_state, 19));
                issue(i_instr(op, ra, rb, imm));
            end
            else
            begin
                rc = int'(take_bits(stim_state, 3));
                issue(r_instr(op, ra, rb, rc));
            end
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected)
        begin
            error_count++;
            $display("ERR %0t: retire %0d %s is %h, expected %h",
                     $time, retired_count, what, got, expected);
        end
    endtask

    // retire_ready toggles 1 ns after the edge, so the handshake is stable at the falling edge
    initial
    begin
        retire_ready = 1'b1;
        ready_state  = SEED;
        forever
        begin
            @(posedge clock);
            #1;
            if (random_ready)
                retire_ready = (take_bits(ready_state, 2) != 32'd0);   // about one gap in four
            else
                retire_ready = 1'b1;
        end
    end

    always @(negedge clock)
    begin
        if (!rst && retire_valid && retire_ready)
        begin
            if (expected_q.size() == 0)
            begin
                error_count++;
                $display("retire record at %0t arrived with no instruction outstanding", $time);
            end
            else
            begin
                exp_rec = expected_q.pop_front();
                check_value("dest", 32'(retire.dest), 32'(exp_rec.dest));
                check_value("reg_write", 32'(retire.reg_write), 32'(exp_rec.reg_write));
                check_value("value", retire.value, exp_rec.value);
            end
            retired_count++;   // every handshake, extra records included
        end
    end

    always @(posedge clock)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("timeout after %0d cycles, %0d of %0d instructions retired",
                     cycle_count, retired_count, sent_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial
    begin
        instr_valid  = 1'b0;
        instr        = '0;
        rst          = 1'b1;
        random_ready = 1'b0;
        stim_state   = SEED;
        sent_count   = 0;
        m_hi         = '0;
        m_lo         = '0;
        for (int i = 0; i < REG_COUNT; i++)
            m_regs[i] = '0;
        for (int i = 0; i < DATA_DEPTH; i++)
            m_mem[i] = '0;
        repeat (2) @(posedge clock);
        #1;
        rst = 1'b0;

        alu_op_sweep();
        mul_hilo_sequence();
        load_store_pairs();
        dependency_chain();

        @(negedge clock);
        random_ready = 1'b1;
        @(posedge clock);
        #1;
        random_stream();

        while (expected_q.size() != 0)
            @(posedge clock);
        repeat (10) @(posedge clock);   // catch any extra retire records

        if (retired_count != sent_count)
            $display("retired %0d records for %0d instructions sent", retired_count, sent_count);
        $display("sent %0d, retired %0d, checks %0d, errors %0d",
                 sent_count, retired_count, check_count, error_count);
        if ((error_count == 0) && (retired_count == sent_count))
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* hw/cpu_core.sv */
`timescale 1ns/100ps

module cpu_core
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic        clock,
    input  logic        rst,
    input  logic        instr_valid,
    input  instr_word_u instr,
    output logic        instr_ready,
    output logic        retire_valid,
    output retire_s     retire,
    input  logic        retire_ready
);

    logic             dec_valid;
    logic             dec_ready;
    decoded_s         dec_rec;
    logic             exe_valid;
    logic             exe_ready;
    executed_s        exe_rec;
    logic [REG_W-1:0] rd_addr_a;
    logic [REG_W-1:0] rd_addr_b;
    logic [31:0]      rd_data_a;
    logic [31:0]      rd_data_b;
    logic             wb_valid;    // write-back strobe, also releases the scoreboard
    logic [REG_W-1:0] wb_reg;
    logic [31:0]      wb_data;

    decode_stage u_decode (
        .clock     (clock),
        .rst       (rst),
        .in_valid  (instr_valid),
        .in_instr  (instr),
        .in_ready  (instr_ready),
        .out_valid (dec_valid),
        .out       (dec_rec),
        .out_ready (dec_ready),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wb_valid  (wb_valid),
        .wb_reg    (wb_reg)
    );

    register_file u_regs (
        .clock     (clock),
        .rst       (rst),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wb_valid),
        .wr_addr   (wb_reg),
        .wr_data   (wb_data)
    );

    execute_stage u_execute (
        .clock     (clock),
        .rst       (rst),
        .in_valid  (dec_valid),
        .in        (dec_rec),
        .in_ready  (dec_ready),
        .out_valid (exe_valid),
        .out       (exe_rec),
        .out_ready (exe_ready)
    );

    memory_stage u_memory (
        .clock        (clock),
        .rst          (rst),
        .in_valid     (exe_valid),
        .in           (exe_rec),
        .in_ready     (exe_ready),
        .retire_valid (retire_valid),
        .retire       (retire),
        .retire_ready (retire_ready),
        .wb_valid     (wb_valid),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data)
    );

endmodule

/* hw/memory_stage.sv */
`timescale 1ns/100ps

module memory_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic             clock,
    input  logic             rst,
    input  logic             in_valid,
    input  executed_s        in,
    output logic             in_ready,
    output logic             retire_valid,
    output retire_s          retire,
    input  logic             retire_ready,
    output logic             wb_valid,
    output logic [REG_W-1:0] wb_reg,
    output logic [31:0]      wb_data
);

    logic [31:0]        ram [DATA_DEPTH];
    logic [DATA_AW-1:0] addr;
    logic               in_fire;
    retire_s            ret;

    assign in_ready = !retire_valid || retire_ready;
    assign in_fire  = in_valid && in_ready;
    assign addr     = in.result[DATA_AW-1:0];   // upper address bits ignored

    // data RAM starts cleared so unwritten words load as zero
    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            for (int i = 0; i < DATA_DEPTH; i++)
            begin
                ram[i] <= '0;
            end
        end
        else if (in_fire && in.mem_write)
        begin
            ram[addr] <= in.st_data;
        end
    end

    always_comb
    begin
        ret.dest      = in.dest;
        ret.reg_write = in.reg_write;
        if (in.mem_write)
            ret.value = in.st_data;
        else if (in.result_src == SRC_MEM)
            ret.value = ram[addr];   // load data
        else
            ret.value = in.result;
    end

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            retire_valid <= 1'b0;
        end
        else if (in_ready)
        begin
            retire_valid <= in_valid;
        end
    end

    always_ff @(posedge clock)
    begin
        if (in_fire)
        begin
            retire <= ret;
        end
    end

    // register write happens on the retire handshake
    assign wb_valid = retire_valid && retire_ready && retire.reg_write;
    assign wb_reg   = retire.dest;
    assign wb_data  = retire.value;

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clock,
    input  logic      rst,
    input  logic      in_valid,
    input  decoded_s  in,
    output logic      in_ready,
    output logic      out_valid,
    output executed_s out,
    input  logic      out_ready
);

    logic               in_fire;
    logic [31:0]        hi;
    logic [31:0]        lo;
    logic signed [63:0] product;
    logic [4:0]         shamt;
    logic [63:0]        rot_r;
    logic [63:0]        rot_l;
    logic [31:0]        alu_y;
    executed_s          exe;

    assign in_ready = !out_valid || out_ready;
    assign in_fire  = in_valid && in_ready;

    assign product = $signed(in.op_a) * $signed(in.op_b);
    assign shamt   = in.op_b[4:0];                 // shifts and rotates use low five bits
    assign rot_r   = {in.op_a, in.op_a} >> shamt;
    assign rot_l   = {in.op_a, in.op_a} << shamt;

    always_comb
    begin
        case (in.alu_op)
            ALU_SUB:  alu_y = in.op_a - in.op_b;
            ALU_AND:  alu_y = in.op_a & in.op_b;
            ALU_OR:   alu_y = in.op_a | in.op_b;
            ALU_ROTR: alu_y = rot_r[31:0];
            ALU_ROTL: alu_y = rot_l[63:32];
            ALU_SHR:  alu_y = in.op_a >> shamt;
            ALU_SHRA: alu_y = $signed(in.op_a) >>> shamt;
            ALU_SHL:  alu_y = in.op_a << shamt;
            ALU_MUL:  alu_y = product[31:0];       // lo half
            ALU_NEG:  alu_y = -in.op_a;
            ALU_NOT:  alu_y = ~in.op_a;
            default:  alu_y = in.op_a + in.op_b;   // also ld/st address
        endcase
    end

    always_comb
    begin
        case (in.opcode)
            OP_MFHI: exe.result = hi;
            OP_MFLO: exe.result = lo;
            default: exe.result = alu_y;
        endcase
        exe.st_data    = in.st_data;
        exe.dest       = in.dest;
        exe.reg_write  = in.reg_write;
        exe.mem_write  = in.mem_write;
        exe.result_src = in.result_src;
    end

    // hi/lo update as mul moves into the output register
    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            hi        <= '0;
            lo        <= '0;
            out_valid <= 1'b0;
        end
        else
        begin
            if (in_fire && in.is_mul)
            begin
                {hi, lo} <= product;
            end
            if (in_ready)
            begin
                out_valid <= in_valid;
            end
        end
    end

    always_ff @(posedge clock)
    begin
        if (in_fire)
        begin
            out <= exe;
        end
    end

endmodule

/* hw/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic             clock,
    input  logic             rst,
    input  logic             in_valid,
    input  instr_word_u      in_instr,
    output logic             in_ready,
    output logic             out_valid,
    output decoded_s         out,
    input  logic             out_ready,
    output logic [REG_W-1:0] rd_addr_a,
    output logic [REG_W-1:0] rd_addr_b,
    input  logic [31:0]      rd_data_a,
    input  logic [31:0]      rd_data_b,
    input  logic             wb_valid,
    input  logic [REG_W-1:0] wb_reg
);

    opcode_e              opcode;
    logic                 is_store;
    logic                 use_a;
    logic                 use_b;
    logic                 use_imm;
    logic [31:0]          imm_ext;
    logic                 hazard;
    logic                 load_ok;
    logic                 in_fire;
    logic [REG_COUNT-1:0] pending;       // one bit per register awaiting write-back
    logic [REG_COUNT-1:0] pending_set;
    logic [REG_COUNT-1:0] pending_clr;
    decoded_s             dec;

    assign opcode   = in_instr.r_form.opcode;
    assign is_store = (opcode == OP_ST);

    // st reads ra as data and rb as base, everything else reads rb/rc
    assign rd_addr_a = is_store ? in_instr.i_form.ra : in_instr.r_form.rb;
    assign rd_addr_b = is_store ? in_instr.i_form.rb : in_instr.r_form.rc;

    assign imm_ext = {{13{in_instr.i_form.imm[18]}}, in_instr.i_form.imm};

    assign use_a   = !(opcode inside {OP_MFHI, OP_MFLO});
    assign use_b   = opcode inside {OP_ST, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ROTR,
                                    OP_ROTL, OP_SHR, OP_SHRA, OP_SHL, OP_MUL};
    assign use_imm = opcode inside {OP_LD, OP_ST, OP_ADDI, OP_ANDI, OP_ORI};

    always_comb
    begin
        dec            = '0;
        dec.opcode     = opcode;
        dec.op_a       = is_store ? rd_data_b : rd_data_a;
        dec.op_b       = use_imm ? imm_ext : rd_data_b;
        dec.st_data    = rd_data_a;
        dec.dest       = in_instr.r_form.ra;
        dec.reg_write  = !is_store;
        dec.mem_write  = is_store;
        dec.is_mul     = (opcode == OP_MUL);

        case (opcode)
            OP_SUB:  dec.alu_op = ALU_SUB;
            OP_AND:  dec.alu_op = ALU_AND;
            OP_ANDI: dec.alu_op = ALU_AND;
            OP_OR:   dec.alu_op = ALU_OR;
            OP_ORI:  dec.alu_op = ALU_OR;
            OP_ROTR: dec.alu_op = ALU_ROTR;
            OP_ROTL: dec.alu_op = ALU_ROTL;
            OP_SHR:  dec.alu_op = ALU_SHR;
            OP_SHRA: dec.alu_op = ALU_SHRA;
            OP_SHL:  dec.alu_op = ALU_SHL;
            OP_MUL:  dec.alu_op = ALU_MUL;
            OP_NEG:  dec.alu_op = ALU_NEG;
            OP_NOT:  dec.alu_op = ALU_NOT;
            default: dec.alu_op = ALU_ADD;   // add, addi and ld/st address
        endcase

        case (opcode)
            OP_LD:   dec.result_src = SRC_MEM;
            OP_MFHI: dec.result_src = SRC_HI;
            OP_MFLO: dec.result_src = SRC_LO;
            default: dec.result_src = SRC_ALU;
        endcase
    end

    // RAW on either source, or WAW on the destination
    assign hazard = (use_a && pending[rd_addr_a])
                 || (use_b && pending[rd_addr_b])
                 || (dec.reg_write && pending[dec.dest]);

    assign load_ok  = !out_valid || out_ready;
    assign in_ready = load_ok && !hazard;
    assign in_fire  = in_valid && in_ready;

    assign pending_set = (in_fire && dec.reg_write && (dec.dest != '0))
                       ? (REG_COUNT'(1) << dec.dest) : '0;
    assign pending_clr = wb_valid ? (REG_COUNT'(1) << wb_reg) : '0;

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            pending   <= '0;
            out_valid <= 1'b0;
        end
        else
        begin
            pending <= (pending & ~pending_clr) | pending_set;
            if (load_ok)
            begin
                out_valid <= in_valid && !hazard;
            end
        end
    end

    always_ff @(posedge clock)
    begin
        if (in_fire)
        begin
            out <= dec;
        end
    end

endmodule

/* hw/register_file.sv */
`timescale 1ns/100ps

module register_file
    import isa_pkg::*;
(
    input  logic             clock,
    input  logic             rst,
    input  logic [REG_W-1:0] rd_addr_a,
    input  logic [REG_W-1:0] rd_addr_b,
    output logic [31:0]      rd_data_a,
    output logic [31:0]      rd_data_b,
    input  logic             wr_en,
    input  logic [REG_W-1:0] wr_addr,
    input  logic [31:0]      wr_data
);

    logic [31:0] regs [REG_COUNT];

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            for (int i = 0; i < REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en && (wr_addr != '0))   // r0 stays zero
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // combinational reads, new value visible the cycle after the write
    assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

/* hw/pipe_pkg.sv */
package pipe_pkg;

    import isa_pkg::*;

    // which value is written back
    typedef enum logic [1:0] {
        SRC_ALU = 2'd0,
        SRC_HI  = 2'd1,
        SRC_MEM = 2'd2,
        SRC_LO  = 2'd3
    } result_src_e;

    // decode -> execute
    typedef struct packed {
        opcode_e          opcode;
        alu_op_e          alu_op;
        logic [31:0]      op_a;       // rb, or base for st
        logic [31:0]      op_b;       // rc or sign-extended constant
        logic [31:0]      st_data;    // ra value for st
        logic [REG_W-1:0] dest;
        logic             reg_write;
        logic             mem_write;
        result_src_e      result_src;
        logic             is_mul;
    } decoded_s;

    // execute -> memory, hi/lo already folded into result
    typedef struct packed {
        logic [31:0]      result;     // alu value or data address
        logic [31:0]      st_data;
        logic [REG_W-1:0] dest;
        logic             reg_write;
        logic             mem_write;
        result_src_e      result_src;
    } executed_s;

    // one record per instruction, in program order
    typedef struct packed {
        logic [REG_W-1:0] dest;
        logic             reg_write;
        logic [31:0]      value;      // st data for stores, lo for mul
    } retire_s;

endpackage

/* hw/isa_pkg.sv */
package isa_pkg;

    localparam int REG_COUNT  = 16;
    localparam int REG_W      = 4;
    localparam int DATA_DEPTH = 256;
    localparam int DATA_AW    = $clog2(DATA_DEPTH);   // word index bits of the data RAM

    // five-bit major opcode, top of the instruction word
    typedef enum logic [4:0] {
        OP_LD   = 5'b00000,
        OP_ST   = 5'b00010,
        OP_ADD  = 5'b00011,
        OP_SUB  = 5'b00100,
        OP_AND  = 5'b00101,
        OP_OR   = 5'b00110,
        OP_ROTR = 5'b00111,
        OP_ROTL = 5'b01000,
        OP_SHR  = 5'b01001,
        OP_SHRA = 5'b01010,
        OP_SHL  = 5'b01011,
        OP_ADDI = 5'b01100,
        OP_ANDI = 5'b01101,
        OP_ORI  = 5'b01110,
        OP_MUL  = 5'b10000,
        OP_NEG  = 5'b10001,
        OP_NOT  = 5'b10010,
        OP_MFLO = 5'b11000,
        OP_MFHI = 5'b11001
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b0001,
        ALU_AND  = 4'b0010,
        ALU_OR   = 4'b0011,
        ALU_ROTR = 4'b0100,
        ALU_ROTL = 4'b0101,
        ALU_SHR  = 4'b0110,
        ALU_SHRA = 4'b0111,
        ALU_SHL  = 4'b1000,
        ALU_MUL  = 4'b1010,   // 1001 was div, not implemented
        ALU_NEG  = 4'b1011,
        ALU_NOT  = 4'b1100
    } alu_op_e;

    // three-register form: ra <= rb op rc
    typedef struct packed {
        opcode_e          opcode;
        logic [REG_W-1:0] ra;
        logic [REG_W-1:0] rb;
        logic [REG_W-1:0] rc;
        logic [14:0]      unused;
    } r_form_s;

    // register plus constant form, also ld/st with C(rb)
    typedef struct packed {
        opcode_e            opcode;
        logic [REG_W-1:0]   ra;
        logic [REG_W-1:0]   rb;
        logic signed [18:0] imm;
    } i_form_s;

    typedef union packed {
        r_form_s r_form;
        i_form_s i_form;
    } instr_word_u;

endpackage
